//--- verilog/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

	// input frame, raster order
	localparam int IMAGE_COLS = 12;
	localparam int IMAGE_ROWS = 12;
	// window edge of every C1 kernel
	localparam int KERNEL = 5;
	// valid convolution positions per frame
	localparam int CONV_COLS = IMAGE_COLS - KERNEL + 1;
	localparam int CONV_ROWS = IMAGE_ROWS - KERNEL + 1;
	localparam int C1_MAPS = 2;
	// 25 weights plus the bias
	localparam int TAPS = KERNEL * KERNEL + 1;
	localparam int COEF_WORDS = C1_MAPS * TAPS;
	localparam int PIX_W = 8;
	// 25 signed 16-bit products plus bias fit in 20 bits
	localparam int ACC_W = 20;
	localparam int AXI_ADDR_W = 8;
	// AXI4-Lite response codes
	localparam logic [1:0] AXI_OKAY = 2'b00;
	localparam logic [1:0] AXI_SLVERR = 2'b10;

	typedef logic signed [PIX_W-1:0] pix_t;
	typedef logic signed [ACC_W-1:0] acc_t;

	// [row][col], row 0 oldest line, col 0 oldest column
	typedef pix_t [KERNEL-1:0][KERNEL-1:0] window_t;

	// bias on top, so tap t of a map sits at bits t*PIX_W
	typedef struct packed {
		pix_t bias;
		pix_t [KERNEL*KERNEL-1:0] weight;
	} map_coef_t;

	// word m*TAPS+t of the register file lands at bits (m*TAPS+t)*PIX_W
	typedef struct packed {
		map_coef_t [C1_MAPS-1:0] map;
	} coef_t;

	// one sample of every feature map, with its strobe
	typedef struct packed {
		logic valid;
		acc_t [C1_MAPS-1:0] value;
	} feat_t;

	// coefficient slave FSM
	typedef enum logic [1:0] {
		AXIL_IDLE,
		AXIL_WRESP,
		AXIL_RDATA
	} axil_state_e;

endpackage

`default_nettype wire

//--- verilog/coef_regs.sv
`default_nettype none

module coef_regs (
	input logic clk,
	input logic rst_n,
	input logic awvalid,
	output logic awready,
	input logic [cnn_pkg::AXI_ADDR_W-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [31:0] wdata,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input logic [cnn_pkg::AXI_ADDR_W-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output cnn_pkg::coef_t coef
);
	import cnn_pkg::*;

	axil_state_e state;
	// word index, one 32-bit slot per coefficient
	logic [AXI_ADDR_W-3:0] wr_idx;
	logic [AXI_ADDR_W-3:0] rd_idx;
	logic wr_ok;
	logic rd_ok;
	// flat coefficient store, map-major then tap
	pix_t [COEF_WORDS-1:0] words;
	pix_t rd_word;

	// byte address to word index
	assign wr_idx = awaddr[AXI_ADDR_W-1:2];
	assign rd_idx = araddr[AXI_ADDR_W-1:2];
	// beyond map 1 bias nothing is mapped
	assign wr_ok = wr_idx < COEF_WORDS;
	assign rd_ok = rd_idx < COEF_WORDS;
	assign rd_word = rd_ok ? words[rd_idx] : '0;
	// address and data always accepted together
	assign wready = awready;
	// index m*TAPS+t lines up with coef.map[m], tap t (tap 25 = bias)
	assign coef = words;

	// store low byte on the write handshake, out-of-range writes dropped
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			words <= '0;
		end else if (state == AXIL_IDLE && awready && wr_ok) begin
			words[wr_idx] <= wdata[PIX_W-1:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= AXIL_IDLE;
			awready <= 1'b0;
			arready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= AXI_OKAY;
			rvalid <= 1'b0;
			rresp <= AXI_OKAY;
			rdata <= '0;
		end else begin
			// ready strobes last one cycle
			awready <= 1'b0;
			arready <= 1'b0;
			case (state)
				AXIL_IDLE: begin
					if (awready) begin
						// write handshake this cycle
						bvalid <= 1'b1;
						bresp <= wr_ok ? AXI_OKAY : AXI_SLVERR;
						state <= AXIL_WRESP;
					end else if (arready) begin
						rvalid <= 1'b1;
						rresp <= rd_ok ? AXI_OKAY : AXI_SLVERR;
						// sign-extend the stored byte
						rdata <= {{(32-PIX_W){rd_word[PIX_W-1]}}, rd_word};
						state <= AXIL_RDATA;
					end else if (awvalid && wvalid) begin
						// writes win over a read in the same cycle
						awready <= 1'b1;
					end else if (arvalid) begin
						arready <= 1'b1;
					end
				end
				AXIL_WRESP: begin
					// hold bvalid until the master takes it
					if (bready) begin
						bvalid <= 1'b0;
						state <= AXIL_IDLE;
					end
				end
				AXIL_RDATA: begin
					if (rready) begin
						rvalid <= 1'b0;
						state <= AXIL_IDLE;
					end
				end
				default: state <= AXIL_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/pixel_window.sv
`default_nettype none

module pixel_window (
	input logic clk,
	input logic rst_n,
	input logic pix_valid,
	input cnn_pkg::pix_t pix,
	output cnn_pkg::window_t win,
	output logic win_valid
);
	import cnn_pkg::*;

	// raster position of the incoming pixel
	logic [$clog2(IMAGE_COLS)-1:0] col;
	logic [$clog2(IMAGE_ROWS)-1:0] row;
	// line_buf[k] holds image row (current - 1 - k)
	pix_t line_buf [KERNEL-1][IMAGE_COLS];
	// column entering the window, index 0 is the top (oldest) line
	pix_t [KERNEL-1:0] new_col;

	// four lines above plus the live pixel
	always_comb begin
		for (int r = 0; r < KERNEL - 1; r++) begin
			new_col[r] = line_buf[KERNEL-2-r][col];
		end
		new_col[KERNEL-1] = pix;
	end

	// counters only move on accepted pixels
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col <= '0;
			row <= '0;
			win_valid <= 1'b0;
		end else begin
			// window fully inside once row and col reach 4
			win_valid <= pix_valid && row >= KERNEL - 1 && col >= KERNEL - 1;
			if (pix_valid) begin
				if (col == IMAGE_COLS - 1) begin
					col <= '0;
					// frame wrap
					if (row == IMAGE_ROWS - 1) begin
						row <= '0;
					end else begin
						row <= row + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// line buffers and window shift together
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			// push this column one line deeper
			line_buf[0][col] <= pix;
			for (int k = 1; k < KERNEL - 1; k++) begin
				line_buf[k][col] <= line_buf[k-1][col];
			end
			// shift left, newest column lands at index KERNEL-1
			for (int r = 0; r < KERNEL; r++) begin
				win[r] <= {new_col[r], win[r][KERNEL-1:1]};
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/conv_relu.sv
`default_nettype none

module conv_relu (
	input logic clk,
	input logic rst_n,
	input cnn_pkg::window_t win,
	input logic win_valid,
	input cnn_pkg::coef_t coef,
	output cnn_pkg::feat_t conv
);
	import cnn_pkg::*;

	// stage one, 8x8 signed products per tap
	logic signed [2*PIX_W-1:0] prod [C1_MAPS][KERNEL*KERNEL];
	pix_t bias_q [C1_MAPS];
	logic prod_valid;
	// stage two
	acc_t sum [C1_MAPS];
	logic conv_valid;
	acc_t [C1_MAPS-1:0] conv_value;

	// valid follows the data through both stages
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prod_valid <= 1'b0;
			conv_valid <= 1'b0;
		end else begin
			prod_valid <= win_valid;
			conv_valid <= prod_valid;
		end
	end

	// tap t pairs with window row t/5, col t%5
	always_ff @(posedge clk) begin
		if (win_valid) begin
			for (int m = 0; m < C1_MAPS; m++) begin
				for (int t = 0; t < KERNEL * KERNEL; t++) begin
					prod[m][t] <= win[t / KERNEL][t % KERNEL] * coef.map[m].weight[t];
				end
				// bias captured with its window
				bias_q[m] <= coef.map[m].bias;
			end
		end
	end

	// adder tree, sign-extended into the accumulator
	always_comb begin
		for (int m = 0; m < C1_MAPS; m++) begin
			sum[m] = acc_t'(bias_q[m]);
			for (int t = 0; t < KERNEL * KERNEL; t++) begin
				sum[m] = sum[m] + acc_t'(prod[m][t]);
			end
		end
	end

	// ReLU, negative sums clamp to zero
	always_ff @(posedge clk) begin
		if (prod_valid) begin
			for (int m = 0; m < C1_MAPS; m++) begin
				conv_value[m] <= sum[m][ACC_W-1] ? '0 : sum[m];
			end
		end
	end

	assign conv = '{valid: conv_valid, value: conv_value};

endmodule

`default_nettype wire

//--- verilog/max_pool.sv
`default_nettype none

module max_pool (
	input logic clk,
	input logic rst_n,
	input cnn_pkg::feat_t conv,
	output cnn_pkg::feat_t pool_out
);
	import cnn_pkg::*;

	// position within the convolution map
	logic [$clog2(CONV_COLS)-1:0] col;
	logic [$clog2(CONV_ROWS)-1:0] row;
	// pooled column, col / 2
	logic [$clog2(CONV_COLS)-2:0] pair_col;
	// even-column sample, waiting for its odd neighbour
	acc_t [C1_MAPS-1:0] pair_q;
	acc_t [C1_MAPS-1:0] pair_max;
	// per-pair max of the even row
	acc_t [C1_MAPS-1:0] half_row [CONV_COLS/2];
	logic pool_valid;
	acc_t [C1_MAPS-1:0] pool_value;

	function automatic acc_t max_acc(input acc_t a, input acc_t b);
		return (a > b) ? a : b;
	endfunction

	assign pair_col = col[$clog2(CONV_COLS)-1:1];

	always_comb begin
		for (int m = 0; m < C1_MAPS; m++) begin
			pair_max[m] = max_acc(pair_q[m], conv.value[m]);
		end
	end

	// sample counters and output strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col <= '0;
			row <= '0;
			pool_valid <= 1'b0;
		end else begin
			// bottom-right of each 2x2 block
			pool_valid <= conv.valid && col[0] && row[0];
			if (conv.valid) begin
				if (col == CONV_COLS - 1) begin
					col <= '0;
					if (row == CONV_ROWS - 1) begin
						row <= '0;
					end else begin
						row <= row + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (conv.valid) begin
			if (!col[0]) begin
				pair_q <= conv.value;
			end else if (!row[0]) begin
				// top half of the block
				half_row[pair_col] <= pair_max;
			end else begin
				// bottom pair against the stored top pair
				for (int m = 0; m < C1_MAPS; m++) begin
					pool_value[m] <= max_acc(pair_max[m], half_row[pair_col][m]);
				end
			end
		end
	end

	assign pool_out = '{valid: pool_valid, value: pool_value};

endmodule

`default_nettype wire

//--- verilog/lenet_c1_top.sv
`default_nettype none

module lenet_c1_top (
	input logic clk,
	input logic rst_n,
	input logic pix_valid,
	input cnn_pkg::pix_t pix,
	input logic awvalid,
	output logic awready,
	input logic [cnn_pkg::AXI_ADDR_W-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [31:0] wdata,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input logic [cnn_pkg::AXI_ADDR_W-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output cnn_pkg::feat_t pool_out
);
	import cnn_pkg::*;

	coef_t coef;
	window_t win;
	logic win_valid;
	feat_t conv;

	// kernels and biases over AXI4-Lite
	coef_regs u_coef_regs (
		.clk(clk), .rst_n(rst_n),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.coef(coef)
	);

	// pixel stream to 5x5 window, 1 cycle
	pixel_window u_pixel_window (
		.clk(clk), .rst_n(rst_n),
		.pix_valid(pix_valid), .pix(pix),
		.win(win), .win_valid(win_valid)
	);

	// C1 plus ReLU, 2 cycles
	conv_relu u_conv_relu (
		.clk(clk), .rst_n(rst_n),
		.win(win), .win_valid(win_valid),
		.coef(coef), .conv(conv)
	);

	// S2, 1 cycle
	max_pool u_max_pool (
		.clk(clk), .rst_n(rst_n),
		.conv(conv), .pool_out(pool_out)
	);

endmodule

`default_nettype wire

//--- test/lenet_c1_assert.sv
`default_nettype none

module lenet_c1_assert (
	input logic clk,
	input logic rst_n,
	input logic pix_valid,
	input logic awvalid,
	input logic awready,
	input logic wvalid,
	input logic wready,
	input logic bvalid,
	input logic bready,
	input logic arready,
	input logic rvalid,
	input logic rready,
	input logic [31:0] rdata,
	input cnn_pkg::feat_t pool_out
);
	timeunit 1ns;
	timeprecision 100ps;
	import cnn_pkg::*;

	// own raster position of the pixel stream
	logic [$clog2(IMAGE_COLS)-1:0] col;
	logic [$clog2(IMAGE_ROWS)-1:0] row;
	// pixel at image row 2r+5, col 2c+5
	logic corner_pix;
	int fail_count = 0;

	assign corner_pix = pix_valid && row >= KERNEL && col >= KERNEL
		&& ((row - KERNEL) % 2) == 0 && ((col - KERNEL) % 2) == 0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col <= '0;
			row <= '0;
		end else if (pix_valid) begin
			col <= (col == IMAGE_COLS - 1) ? '0 : col + 1'b1;
			if (col == IMAGE_COLS - 1) begin
				row <= (row == IMAGE_ROWS - 1) ? '0 : row + 1'b1;
			end
		end
	end

	reset_quiet: assert property (@(posedge clk)
		!rst_n |-> !awready && !wready && !arready && !bvalid && !rvalid && !pool_out.valid)
		else begin
			fail_count++;
			$error("valid or ready output high during reset");
		end

	bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid)
		else begin
			fail_count++;
			$error("bvalid dropped before bready");
		end

	rvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else begin
			fail_count++;
			$error("rvalid or rdata changed before rready");
		end

	// no new request while a response is pending
	busy_refuse: assert property (@(posedge clk) disable iff (!rst_n)
		(bvalid || rvalid) |-> !awready && !wready && !arready)
		else begin
			fail_count++;
			$error("request accepted during a pending response");
		end

	aw_w_pair: assert property (@(posedge clk) disable iff (!rst_n)
		awready |-> wready && awvalid && wvalid)
		else begin
			fail_count++;
			$error("awready without wready or without both valids");
		end

	pool_timing: assert property (@(posedge clk) disable iff (!rst_n)
		pool_out.valid == $past(corner_pix, 4))
		else begin
			fail_count++;
			$error("pool_out.valid not 4 cycles after a block corner pixel");
		end

endmodule

bind lenet_c1_top lenet_c1_assert u_lenet_c1_assert (
	.clk(clk), .rst_n(rst_n), .pix_valid(pix_valid),
	.awvalid(awvalid), .awready(awready), .wvalid(wvalid), .wready(wready),
	.bvalid(bvalid), .bready(bready), .arready(arready),
	.rvalid(rvalid), .rready(rready), .rdata(rdata),
	.pool_out(pool_out)
);

`default_nettype wire

//--- test/tb_lenet_c1.sv
`default_nettype none

module tb_lenet_c1;
	timeunit 1ns;
	timeprecision 100ps;
	import cnn_pkg::*;

	// limits in clock cycles
	localparam int HS_LIMIT = 64;
	localparam int DRAIN_LIMIT = 2000;
	// 2x2 stride-2 pooling of the conv map
	localparam int POOL_PER_FRAME = (CONV_ROWS / 2) * (CONV_COLS / 2);
	localparam int SEL_AWREADY = 0;
	localparam int SEL_BVALID = 1;
	localparam int SEL_ARREADY = 2;
	localparam int SEL_RVALID = 3;

	logic clk;
	logic rst_n;
	logic pix_valid;
	pix_t pix;
	logic awvalid;
	logic awready;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic wvalid;
	logic wready;
	logic [31:0] wdata;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic arvalid;
	logic arready;
	logic [AXI_ADDR_W-1:0] araddr;
	logic rvalid;
	logic rready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	feat_t pool_out;

	int mismatches = 0;
	int timeouts = 0;
	int failures = 0;
	logic [15:0] lfsr = 16'd48099;
	// model copy of what was written, bias at tap TAPS-1
	pix_t coef_mem [C1_MAPS][TAPS];
	pix_t img [IMAGE_ROWS][IMAGE_COLS];
	// expected pool results in arrival order, both frames
	acc_t [C1_MAPS-1:0] exp_mem [2*POOL_PER_FRAME];
	acc_t [C1_MAPS-1:0] exp_head;
	int out_idx;

	lenet_c1_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// count results as they leave the DUT
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_idx <= 0;
		end else if (pool_out.valid) begin
			out_idx <= out_idx + 1;
		end
	end

	assign exp_head = exp_mem[out_idx];

	pool_check: assert property (@(posedge clk) disable iff (!rst_n)
		pool_out.valid |-> pool_out.value == exp_head)
	else begin
		mismatches++;
		$display("MISMATCH time=%0t pool_out.value got=%h expected=%h", $time,
			$sampled(pool_out.value), $sampled(exp_head));
	end

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic expect_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			mismatches++;
			$display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
		end
	endtask

	// sampled on the falling edge, away from the DUT updates
	task automatic wait_signal(input int sel, input string what);
		int n;
		logic hit;
		n = 0;
		hit = 1'b0;
		while (!hit && n < HS_LIMIT) begin
			@(negedge clk);
			n++;
			case (sel)
				SEL_AWREADY: hit = awready;
				SEL_BVALID: hit = bvalid;
				SEL_ARREADY: hit = arready;
				default: hit = rvalid;
			endcase
		end
		if (!hit) begin
			timeouts++;
			$display("timeout while waiting for %s", what);
		end
	endtask

	// stall > 0 holds bready low and raises a competing read meanwhile
	task automatic axi_write(input int idx, input logic [31:0] data, input int stall,
			output logic [1:0] resp);
		awaddr = AXI_ADDR_W'(idx * 4);
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = (stall == 0);
		wait_signal(SEL_AWREADY, "the write address handshake");
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		wait_signal(SEL_BVALID, "the write response");
		resp = bresp;
		if (stall > 0) begin
			@(posedge clk);
			#1;
			// left pending, the next read picks it up
			araddr = awaddr;
			arvalid = 1'b1;
			repeat (stall) @(posedge clk);
			#1;
			bready = 1'b1;
		end
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	// stall > 0 holds rready low and raises a competing write of the same word
	task automatic axi_read(input int idx, input int stall, output logic [31:0] data,
			output logic [1:0] resp);
		araddr = AXI_ADDR_W'(idx * 4);
		arvalid = 1'b1;
		rready = (stall == 0);
		wait_signal(SEL_ARREADY, "the read address handshake");
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		wait_signal(SEL_RVALID, "the read data");
		data = rdata;
		resp = rresp;
		if (stall > 0) begin
			@(posedge clk);
			#1;
			awaddr = araddr;
			wdata = data;
			awvalid = 1'b1;
			wvalid = 1'b1;
			repeat (stall) @(posedge clk);
			#1;
			rready = 1'b1;
		end
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	// random weights, junk in the upper bits of wdata
	task automatic load_coefs(input logic neg_bias);
		logic [1:0] resp;
		for (int m = 0; m < C1_MAPS; m++) begin
			for (int t = 0; t < TAPS; t++) begin
				coef_mem[m][t] = pix_t'(take_bits(PIX_W));
				if (t == TAPS - 1 && neg_bias) begin
					coef_mem[m][t][PIX_W-1] = 1'b1;
				end
				axi_write(m * TAPS + t, {24'(take_bits(24)), coef_mem[m][t]}, 0, resp);
				expect_word("bresp", 32'(resp), 32'(AXI_OKAY));
			end
		end
	endtask

	task automatic check_readback();
		logic [31:0] data;
		logic [1:0] resp;
		pix_t c;
		for (int m = 0; m < C1_MAPS; m++) begin
			for (int t = 0; t < TAPS; t++) begin
				c = coef_mem[m][t];
				axi_read(m * TAPS + t, 0, data, resp);
				expect_word("rdata", data, {{(32-PIX_W){c[PIX_W-1]}}, c});
				expect_word("rresp", 32'(resp), 32'(AXI_OKAY));
			end
		end
	endtask

	// valid 5x5 conv, bias, relu, then max of each 2x2 block
	task automatic build_expected(input int frame);
		int conv_v [C1_MAPS][CONV_ROWS][CONV_COLS];
		int s;
		int best;
		for (int m = 0; m < C1_MAPS; m++) begin
			for (int y = 0; y < CONV_ROWS; y++) begin
				for (int x = 0; x < CONV_COLS; x++) begin
					s = int'(coef_mem[m][TAPS-1]);
					for (int i = 0; i < KERNEL; i++) begin
						for (int j = 0; j < KERNEL; j++) begin
							s += int'(img[y+i][x+j]) * int'(coef_mem[m][i*KERNEL+j]);
						end
					end
					conv_v[m][y][x] = (s < 0) ? 0 : s;
				end
			end
			for (int py = 0; py < CONV_ROWS / 2; py++) begin
				for (int px = 0; px < CONV_COLS / 2; px++) begin
					best = 0;
					for (int k = 0; k < 4; k++) begin
						s = conv_v[m][2*py+k/2][2*px+k%2];
						best = (s > best) ? s : best;
					end
					exp_mem[frame*POOL_PER_FRAME+py*(CONV_COLS/2)+px][m] = acc_t'(best);
				end
			end
		end
	endtask

	task automatic run_frame(input int frame);
		int n;
		for (int r = 0; r < IMAGE_ROWS; r++) begin
			for (int c = 0; c < IMAGE_COLS; c++) begin
				img[r][c] = pix_t'(take_bits(PIX_W));
			end
		end
		build_expected(frame);
		// raster order, 0 to 3 idle cycles before each pixel
		for (int r = 0; r < IMAGE_ROWS; r++) begin
			for (int c = 0; c < IMAGE_COLS; c++) begin
				repeat (take_bits(2)) begin
					pix_valid = 1'b0;
					@(posedge clk);
					#1;
				end
				pix_valid = 1'b1;
				pix = img[r][c];
				@(posedge clk);
				#1;
			end
		end
		pix_valid = 1'b0;
		n = 0;
		while (out_idx < (frame + 1) * POOL_PER_FRAME && n < DRAIN_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (out_idx < (frame + 1) * POOL_PER_FRAME) begin
			timeouts++;
			$display("timeout while waiting for the pool outputs of frame %0d", frame);
		end
		// nothing extra may follow
		repeat (8) @(negedge clk);
		assert (out_idx == (frame + 1) * POOL_PER_FRAME) else begin
			failures++;
			$display("frame %0d gave %0d pool outputs in total, expected %0d", frame,
				out_idx, (frame + 1) * POOL_PER_FRAME);
		end
		@(posedge clk);
		#1;
	endtask

	initial begin
		logic [31:0] data;
		logic [1:0] resp;
		rst_n = 1'b1;
		pix_valid = 1'b0;
		pix = '0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		#1 rst_n = 1'b0;
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
		@(posedge clk);
		#1;
		load_coefs(1'b0);
		// beyond the array, no effect
		axi_write(COEF_WORDS, 32'h0000_005A, 0, resp);
		expect_word("bresp", 32'(resp), 32'(AXI_SLVERR));
		axi_write(63, 32'h0000_00A5, 0, resp);
		expect_word("bresp", 32'(resp), 32'(AXI_SLVERR));
		axi_read(COEF_WORDS, 0, data, resp);
		expect_word("rresp", 32'(resp), 32'(AXI_SLVERR));
		check_readback();
		// held write response, then the queued read completes
		axi_write(3, {24'h0, coef_mem[0][3]}, 6, resp);
		expect_word("bresp", 32'(resp), 32'(AXI_OKAY));
		axi_read(3, 0, data, resp);
		expect_word("rdata", data, {{(32-PIX_W){coef_mem[0][3][PIX_W-1]}}, coef_mem[0][3]});
		// held read data, then the queued write completes
		axi_read(TAPS, 6, data, resp);
		expect_word("rdata", data,
			{{(32-PIX_W){coef_mem[1][0][PIX_W-1]}}, coef_mem[1][0]});
		axi_write(TAPS, data, 0, resp);
		expect_word("bresp", 32'(resp), 32'(AXI_OKAY));
		run_frame(0);
		// negative biases push sums below zero
		load_coefs(1'b1);
		run_frame(1);
		$display("errors: mismatch %0d, timeout %0d, other %0d, assertion %0d", mismatches,
			timeouts, failures, uut.u_lenet_c1_assert.fail_count);
		if (mismatches + timeouts + failures + uut.u_lenet_c1_assert.fail_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
verilog/cnn_pkg.sv
verilog/coef_regs.sv
verilog/pixel_window.sv
verilog/conv_relu.sv
verilog/max_pool.sv
verilog/lenet_c1_top.sv
test/lenet_c1_assert.sv
test/tb_lenet_c1.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_lenet_c1
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(OBJ_DIR)/V%: $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $* --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
